//--- logic/inverter_macros.svh
`ifndef INVERTER_MACROS_SVH
`define INVERTER_MACROS_SVH

`default_nettype none

// Serial link timing
// Clock cycles per UART bit, sampled at mid-bit
`define BIT_CYCLES 16

// Bridge timing
// Cycles both gates of a leg stay off before the new gate turns on
`define DEAD_CYCLES 4

// Electrical angle
// 4096 counts per electrical turn
`define ANGLE_W 12

`default_nettype wire

`endif

//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Receiver FSM
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_start  = 3'd1,
        st_data   = 3'd2,
        st_parity = 3'd3,
        st_stop   = 3'd4
    } rx_state_t;

    // Two-byte frame assembler FSM
    // link_error is sticky until reset
    typedef enum logic [1:0] {
        wait_high  = 2'd0,
        wait_low   = 2'd1,
        link_error = 2'd2
    } frame_state_t;

endpackage

`default_nettype wire

//--- logic/drive_pkg.sv
`default_nettype none

package drive_pkg;

    // Six-step sectors, 60 electrical degrees each
    typedef enum logic [2:0] {
        sector_0 = 3'd0,
        sector_1 = 3'd1,
        sector_2 = 3'd2,
        sector_3 = 3'd3,
        sector_4 = 3'd4,
        sector_5 = 3'd5
    } sector_t;

    // Half-bridge leg command
    typedef enum logic [1:0] {
        leg_off  = 2'd0,
        leg_high = 2'd1,
        leg_low  = 2'd2
    } leg_cmd_t;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
`include "inverter_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_done,
    output logic       rx_error
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(`BIT_CYCLES);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`BIT_CYCLES / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`BIT_CYCLES - 1);

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic             rx_prev;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             parity_bit;

    wire rx_s      = rx_sync[1];
    wire fall_edge = rx_prev & ~rx_s;
    wire mid_start = (bit_cnt == HALF_BIT);
    wire mid_bit   = (bit_cnt == FULL_BIT);

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            bit_cnt <= bit_cnt + 1'b1;
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    if (fall_edge) state <= st_start;
                end
                st_start: begin
                    // Recheck at mid-bit so a glitch does not start a byte
                    if (mid_start) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (mid_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_parity;
                    end
                end
                st_parity: begin
                    if (mid_bit) begin
                        bit_cnt <= '0;
                        state   <= st_stop;
                    end
                end
                st_stop: begin
                    if (mid_bit) begin
                        // Even parity: data plus parity bit has an even count of ones
                        rx_done  <= 1'b1;
                        rx_error <= (^shift ^ parity_bit) | ~rx_s;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data shifts in LSB first
    always_ff @(posedge clk) begin
        if (state == st_data && mid_bit) shift <= {rx_s, shift[7:1]};
        if (state == st_parity && mid_bit) parity_bit <= rx_s;
    end

    assign rx_data = shift;

endmodule

`default_nettype wire

//--- logic/angle_frame.sv
`include "inverter_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module angle_frame (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          rx_data,
    input  logic                rx_done,
    input  logic                rx_error,
    output logic [`ANGLE_W-1:0] angle,
    output logic                angle_valid,
    output logic                armed,
    output logic                link_fault
);

    import uart_pkg::*;

    frame_state_t          state;
    logic [`ANGLE_W-9:0]   high_part;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= wait_high;
            angle       <= '0;
            angle_valid <= 1'b0;
            armed       <= 1'b0;
        end else begin
            angle_valid <= 1'b0;
            case (state)
                wait_high: begin
                    if (rx_done) state <= rx_error ? link_error : wait_low;
                end
                wait_low: begin
                    if (rx_done && rx_error) begin
                        state <= link_error;
                    end else if (rx_done) begin
                        // Whole angle loads at once, never half a frame
                        angle       <= {high_part, rx_data};
                        angle_valid <= 1'b1;
                        armed       <= 1'b1;
                        state       <= wait_high;
                    end
                end
                link_error: state <= link_error;
                default:    state <= link_error;
            endcase
        end
    end

    // High nibble held until the low byte arrives, upper nibble of byte dropped
    always_ff @(posedge clk) begin
        if (state == wait_high && rx_done) high_part <= rx_data[`ANGLE_W-9:0];
    end

    assign link_fault = (state == link_error);

endmodule

`default_nettype wire

//--- logic/commutation.sv
`include "inverter_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module commutation (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`ANGLE_W-1:0] angle,
    input  logic                armed,
    input  logic                link_fault,
    input  logic                shoot,
    output drive_pkg::leg_cmd_t leg_a,
    output drive_pkg::leg_cmd_t leg_b,
    output drive_pkg::leg_cmd_t leg_c
);

    import drive_pkg::*;

    // Sector boundaries, 4096 / 6 rounded
    localparam logic [`ANGLE_W-1:0] BOUND_1 = `ANGLE_W'(683);
    localparam logic [`ANGLE_W-1:0] BOUND_2 = `ANGLE_W'(1366);
    localparam logic [`ANGLE_W-1:0] BOUND_3 = `ANGLE_W'(2048);
    localparam logic [`ANGLE_W-1:0] BOUND_4 = `ANGLE_W'(2731);
    localparam logic [`ANGLE_W-1:0] BOUND_5 = `ANGLE_W'(3414);

    sector_t sector;
    logic    enable;

    always_comb begin
        if (angle >= BOUND_5)      sector = sector_5;
        else if (angle >= BOUND_4) sector = sector_4;
        else if (angle >= BOUND_3) sector = sector_3;
        else if (angle >= BOUND_2) sector = sector_2;
        else if (angle >= BOUND_1) sector = sector_1;
        else                       sector = sector_0;
    end

    assign enable = shoot & armed & ~link_fault;

    // 120-degree conduction: one leg high, one low, one floating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leg_a <= leg_off;
            leg_b <= leg_off;
            leg_c <= leg_off;
        end else if (!enable) begin
            leg_a <= leg_off;
            leg_b <= leg_off;
            leg_c <= leg_off;
        end else begin
            case (sector)
                sector_0: begin
                    leg_a <= leg_high;
                    leg_b <= leg_low;
                    leg_c <= leg_off;
                end
                sector_1: begin
                    leg_a <= leg_high;
                    leg_b <= leg_off;
                    leg_c <= leg_low;
                end
                sector_2: begin
                    leg_a <= leg_off;
                    leg_b <= leg_high;
                    leg_c <= leg_low;
                end
                sector_3: begin
                    leg_a <= leg_low;
                    leg_b <= leg_high;
                    leg_c <= leg_off;
                end
                sector_4: begin
                    leg_a <= leg_low;
                    leg_b <= leg_off;
                    leg_c <= leg_high;
                end
                default: begin
                    leg_a <= leg_off;
                    leg_b <= leg_low;
                    leg_c <= leg_high;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/gate_driver.sv
`include "inverter_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module gate_driver (
    input  logic                clk,
    input  logic                rst_n,
    input  drive_pkg::leg_cmd_t leg_a,
    input  drive_pkg::leg_cmd_t leg_b,
    input  drive_pkg::leg_cmd_t leg_c,
    output logic                gate_a_hi,
    output logic                gate_a_lo,
    output logic                gate_b_hi,
    output logic                gate_b_lo,
    output logic                gate_c_hi,
    output logic                gate_c_lo
);

    import drive_pkg::*;

    localparam int DEAD_W = $clog2(`DEAD_CYCLES + 1);
    localparam logic [DEAD_W-1:0] DEAD_LOAD = DEAD_W'(`DEAD_CYCLES);

    leg_cmd_t          leg_in  [3];
    leg_cmd_t          applied [3];
    logic [DEAD_W-1:0] dead_cnt [3];
    logic              gate_hi [3];
    logic              gate_lo [3];

    assign leg_in[0] = leg_a;
    assign leg_in[1] = leg_b;
    assign leg_in[2] = leg_c;

    for (genvar i = 0; i < 3; i++) begin : g_leg
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                applied[i]  <= leg_off;
                dead_cnt[i] <= '0;
                gate_hi[i]  <= 1'b0;
                gate_lo[i]  <= 1'b0;
            end else if (leg_in[i] != applied[i]) begin
                // Any change opens both switches first
                applied[i]  <= leg_in[i];
                gate_hi[i]  <= 1'b0;
                gate_lo[i]  <= 1'b0;
                dead_cnt[i] <= (leg_in[i] == leg_off) ? '0 : DEAD_LOAD;
            end else if (dead_cnt[i] != '0) begin
                dead_cnt[i] <= dead_cnt[i] - 1'b1;
                if (dead_cnt[i] == DEAD_W'(1)) begin
                    gate_hi[i] <= (applied[i] == leg_high);
                    gate_lo[i] <= (applied[i] == leg_low);
                end
            end
        end
    end

    assign gate_a_hi = gate_hi[0];
    assign gate_a_lo = gate_lo[0];
    assign gate_b_hi = gate_hi[1];
    assign gate_b_lo = gate_lo[1];
    assign gate_c_hi = gate_hi[2];
    assign gate_c_lo = gate_lo[2];

endmodule

`default_nettype wire

//--- logic/inverter_top.sv
`include "inverter_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module inverter_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    input  logic shoot,
    output logic gate_a_hi,
    output logic gate_a_lo,
    output logic gate_b_hi,
    output logic gate_b_lo,
    output logic gate_c_hi,
    output logic gate_c_lo,
    output logic led_ready,
    output logic led_error
);

    import drive_pkg::*;

    logic [7:0]          rx_data;
    logic                rx_done;
    logic                rx_error;
    logic [`ANGLE_W-1:0] angle;
    logic                armed;
    logic                link_fault;
    leg_cmd_t            leg_a;
    leg_cmd_t            leg_b;
    leg_cmd_t            leg_c;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_done  (rx_done),
        .rx_error (rx_error)
    );

    // Frame strobe not needed downstream, angle is held
    angle_frame u_angle_frame (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .rx_error    (rx_error),
        .angle       (angle),
        .angle_valid (),
        .armed       (armed),
        .link_fault  (link_fault)
    );

    commutation u_commutation (
        .clk        (clk),
        .rst_n      (rst_n),
        .angle      (angle),
        .armed      (armed),
        .link_fault (link_fault),
        .shoot      (shoot),
        .leg_a      (leg_a),
        .leg_b      (leg_b),
        .leg_c      (leg_c)
    );

    gate_driver u_gate_driver (
        .clk       (clk),
        .rst_n     (rst_n),
        .leg_a     (leg_a),
        .leg_b     (leg_b),
        .leg_c     (leg_c),
        .gate_a_hi (gate_a_hi),
        .gate_a_lo (gate_a_lo),
        .gate_b_hi (gate_b_hi),
        .gate_b_lo (gate_b_lo),
        .gate_c_hi (gate_c_hi),
        .gate_c_lo (gate_c_lo)
    );

    assign led_ready = armed;
    assign led_error = link_fault;

endmodule

`default_nettype wire

//--- sim/inverter_tb.sv
`include "inverter_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module inverter_tb;

    import drive_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int N_DIRECTED     = 19;
    localparam int N_ROWS         = N_DIRECTED + 6;
    localparam int TIMEOUT_CYCLES = N_ROWS * (22 * `BIT_CYCLES + 40) + 200;

    // Gates ordered a_hi a_lo b_hi b_lo c_hi c_lo
    typedef struct packed {
        logic [11:0] angle;
        logic        shoot;
        logic        corrupt;
        logic [5:0]  gates;
    } row_t;

    logic clk;
    logic rst_n;
    logic rx;
    logic shoot;
    logic gate_a_hi;
    logic gate_a_lo;
    logic gate_b_hi;
    logic gate_b_lo;
    logic gate_c_hi;
    logic gate_c_lo;
    logic led_ready;
    logic led_error;

    row_t       rows [N_ROWS];
    integer     seed;
    int         cycle_count = 0;
    int         off_run [3] = '{0, 0, 0};
    logic [1:0] prev_pair [3] = '{2'b00, 2'b00, 2'b00};
    logic       ready_exp;
    logic       error_exp;
    string      gate_names [6] = '{"gate_a_hi", "gate_a_lo", "gate_b_hi",
                                   "gate_b_lo", "gate_c_hi", "gate_c_lo"};

    wire [5:0] gates = {gate_a_hi, gate_a_lo, gate_b_hi, gate_b_lo, gate_c_hi, gate_c_lo};

    inverter_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .shoot     (shoot),
        .gate_a_hi (gate_a_hi),
        .gate_a_lo (gate_a_lo),
        .gate_b_hi (gate_b_hi),
        .gate_b_lo (gate_b_lo),
        .gate_c_hi (gate_c_hi),
        .gate_c_lo (gate_c_lo),
        .led_ready (led_ready),
        .led_error (led_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch at %0t: %s expected %0h, actual %0h",
                               $time, name, expected, actual));
    endtask

    task automatic check_outputs(input logic [5:0] expected);
        for (int k = 0; k < 6; k++)
            check_value(gate_names[k], 32'(expected[5 - k]), 32'(gates[5 - k]));
        check_value("led_ready", 32'(ready_exp), 32'(led_ready));
        check_value("led_error", 32'(error_exp), 32'(led_error));
    endtask

    // Six-step table with one leg high, one low and one off
    function automatic logic [5:0] six_step_pattern(input logic [11:0] angle);
        sector_t sec;
        if (angle >= 12'd3414)      sec = sector_5;
        else if (angle >= 12'd2731) sec = sector_4;
        else if (angle >= 12'd2048) sec = sector_3;
        else if (angle >= 12'd1366) sec = sector_2;
        else if (angle >= 12'd683)  sec = sector_1;
        else                        sec = sector_0;
        case (sec)
            sector_0: six_step_pattern = 6'b10_01_00;
            sector_1: six_step_pattern = 6'b10_00_01;
            sector_2: six_step_pattern = 6'b00_10_01;
            sector_3: six_step_pattern = 6'b01_10_00;
            sector_4: six_step_pattern = 6'b01_00_10;
            default:  six_step_pattern = 6'b00_01_10;
        endcase
    endfunction

    // Each sector's lower boundary and the value just below it
    task automatic load_table;
        logic [31:0] rand_val;
        rows[0]  = '{12'd0,    1'b1, 1'b0, 6'b10_01_00};
        rows[1]  = '{12'd682,  1'b1, 1'b0, 6'b10_01_00};
        rows[2]  = '{12'd683,  1'b1, 1'b0, 6'b10_00_01};
        rows[3]  = '{12'd1365, 1'b1, 1'b0, 6'b10_00_01};
        rows[4]  = '{12'd1366, 1'b1, 1'b0, 6'b00_10_01};
        rows[5]  = '{12'd2047, 1'b1, 1'b0, 6'b00_10_01};
        rows[6]  = '{12'd2048, 1'b1, 1'b0, 6'b01_10_00};
        rows[7]  = '{12'd2730, 1'b1, 1'b0, 6'b01_10_00};
        rows[8]  = '{12'd2731, 1'b1, 1'b0, 6'b01_00_10};
        rows[9]  = '{12'd3413, 1'b1, 1'b0, 6'b01_00_10};
        rows[10] = '{12'd3414, 1'b1, 1'b0, 6'b00_01_10};
        rows[11] = '{12'd4095, 1'b1, 1'b0, 6'b00_01_10};
        // Shoot off and back on
        rows[12] = '{12'd4095, 1'b0, 1'b0, 6'b00_00_00};
        rows[13] = '{12'd4095, 1'b1, 1'b0, 6'b00_01_10};
        rows[14] = '{12'd1000, 1'b0, 1'b0, 6'b00_00_00};
        rows[15] = '{12'd1000, 1'b1, 1'b0, 6'b10_00_01};
        // Legs A and C swap sides directly
        rows[16] = '{12'd3000, 1'b1, 1'b0, 6'b01_00_10};
        // Bad parity latches the link error
        rows[17] = '{12'd2000, 1'b1, 1'b1, 6'b00_00_00};
        rows[18] = '{12'd500,  1'b1, 1'b0, 6'b00_00_00};
        for (int i = N_DIRECTED; i < N_ROWS; i++) begin
            rand_val = $random(seed);
            rows[i] = '{rand_val[11:0], 1'b1, 1'b0, six_step_pattern(rand_val[11:0])};
        end
    endtask

    task automatic drive_bit(input logic value);
        @(posedge clk);
        #(DRIVE_DELAY) rx = value;
        repeat (`BIT_CYCLES - 1) @(posedge clk);
    endtask

    // Start, 8 data bits LSB first, even parity, stop
    task automatic send_byte(input logic [7:0] data, input logic flip_parity);
        drive_bit(1'b0);
        for (int b = 0; b < 8; b++)
            drive_bit(data[b]);
        drive_bit(^data ^ flip_parity);
        drive_bit(1'b1);
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #(DRIVE_DELAY) rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY) rst_n = 1'b1;
        ready_exp = 1'b0;
        error_exp = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_row(input row_t row);
        // Upper nibble of the first byte carries junk the DUT must ignore
        send_byte({4'ha, row.angle[11:8]}, row.corrupt);
        send_byte(row.angle[7:0], 1'b0);
        @(posedge clk);
        #(DRIVE_DELAY) shoot = row.shoot;
        repeat (`BIT_CYCLES + 8) @(posedge clk);
        @(negedge clk);
        if (row.corrupt)
            error_exp = 1'b1;
        else if (!error_exp)
            ready_exp = 1'b1;
        check_outputs(row.gates);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run($sformatf("timeout: run still busy after %0d clock cycles", cycle_count));
    end

    // No shoot-through, and a gate only turns on after a full dead time
    always @(negedge clk) begin : dead_time_monitor
        logic hi;
        logic lo;
        for (int leg = 0; leg < 3; leg++) begin
            hi = gates[5 - 2 * leg];
            lo = gates[4 - 2 * leg];
            if (hi === 1'b1 && lo === 1'b1)
                fail_run($sformatf("leg %0d has both gates on at %0t", leg, $time));
            if (hi === 1'b1 || lo === 1'b1) begin
                if (prev_pair[leg] === 2'b00 && off_run[leg] < `DEAD_CYCLES)
                    fail_run($sformatf("leg %0d gate turned on after only %0d off cycles",
                                       leg, off_run[leg]));
                if (prev_pair[leg] !== 2'b00 && prev_pair[leg] !== {hi, lo})
                    fail_run($sformatf("leg %0d switched sides without dead time", leg));
                off_run[leg] = 0;
            end else begin
                off_run[leg] = off_run[leg] + 1;
            end
            prev_pair[leg] = {hi, lo};
        end
    end

    initial begin
        seed      = 32'had1e;
        rx        = 1'b1;
        shoot     = 1'b0;
        rst_n     = 1'b0;
        ready_exp = 1'b0;
        error_exp = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY) rst_n = 1'b1;
        // Bridge stays off before any frame even with shoot high
        @(posedge clk);
        #(DRIVE_DELAY) shoot = 1'b1;
        repeat (`BIT_CYCLES) @(posedge clk);
        @(negedge clk);
        check_outputs(6'b0);
        for (int i = 0; i < N_ROWS; i++) begin
            if (i == N_DIRECTED) begin
                apply_reset();
                check_outputs(6'b0);
            end
            run_row(rows[i]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/uart_pkg.sv
logic/drive_pkg.sv
logic/uart_rx.sv
logic/angle_frame.sv
logic/commutation.sv
logic/gate_driver.sv
logic/inverter_top.sv
sim/inverter_tb.sv

//--- Makefile
# Verilator build and run of the inverter testbench

VERILATOR ?= verilator
TOP       ?= inverter_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timescale 1ns/100ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
